//--- logic/ppu_bus_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_bus_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire ppu_pkg::cpu_req_t  req,
    input  wire ppu_pkg::ppu_mode_t mode,
    input  wire [7:0]               line,
    output ppu_pkg::vram_cpu_t      vram_cpu,
    input  wire [7:0]               vram_rdata,
    output ppu_pkg::bg_cfg_t        cfg,
    output logic [7:0]              bgp,
    output logic [7:0]              d_rd,
    output logic                    rd_valid
);

    logic       in_vram;
    logic [3:0] stat_hi;    // STAT bits 6:3
    logic [7:0] reg_rdata;
    logic [7:0] rdata_q;
    logic       vram_rd_q;
    logic       rd_q;

    assign in_vram = (req.addr >= ppu_pkg::vram_base) && (req.addr <= ppu_pkg::vram_last);

    // VRAM port, the memory applies the mode check
    assign vram_cpu = '{
        addr:  req.addr[12:0],
        wdata: req.wdata,
        we:    req.wr && in_vram,
        re:    req.rd && in_vram
    };

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cfg.lcdc.raw <= 8'h00;
            cfg.scy      <= 8'h00;
            cfg.scx      <= 8'h00;
            stat_hi      <= 4'h0;
            bgp          <= 8'hFC;
        end
        else if (req.wr)
        begin
            case (req.addr)
                ppu_pkg::addr_lcdc: cfg.lcdc.raw <= req.wdata;
                ppu_pkg::addr_stat: stat_hi <= req.wdata[6:3];  // Mode bits stay live
                ppu_pkg::addr_scy:  cfg.scy <= req.wdata;
                ppu_pkg::addr_scx:  cfg.scx <= req.wdata;
                ppu_pkg::addr_bgp:  bgp <= req.wdata;
            endcase
        end
    end

    // Unmapped and OAM space fall through to FF
    always_comb
    begin
        case (req.addr)
            ppu_pkg::addr_lcdc: reg_rdata = cfg.lcdc.raw;
            ppu_pkg::addr_stat: reg_rdata = {1'b1, stat_hi, 1'b0, mode};
            ppu_pkg::addr_scy:  reg_rdata = cfg.scy;
            ppu_pkg::addr_scx:  reg_rdata = cfg.scx;
            ppu_pkg::addr_ly:   reg_rdata = line;
            ppu_pkg::addr_bgp:  reg_rdata = bgp;
            default:            reg_rdata = 8'hFF;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Read return, two cycles for every address
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_q     <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_q     <= req.rd;
            rd_valid <= rd_q;
        end
    end

    // Register data waits one cycle to line up with VRAM
    always_ff @(posedge clk)
    begin
        vram_rd_q <= in_vram;
        rdata_q   <= reg_rdata;
        if (rd_q)
            d_rd <= vram_rd_q ? vram_rdata : rdata_q;
    end

endmodule

`default_nettype wire

//--- logic/ppu_fetcher.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_fetcher #(
    parameter int oam_cycles = 80
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire ppu_pkg::bg_cfg_t   cfg,
    input  wire                     line_start,
    input  wire                     in_vblank,
    input  wire [8:0]               h_count,
    input  wire [7:0]               line,
    output ppu_pkg::ppu_mode_t      mode,
    output logic [12:0]             fetch_addr,
    input  wire [7:0]               fetch_data,
    output logic                    push,
    output logic [15:0]             tile_bits,
    input  wire                     credit_return,
    input  wire                     line_done
);

    // A states present an address and B states take the data
    typedef enum logic [3:0] {
        st_idle, st_oam,
        st_map_a, st_map_b, st_lo_a, st_lo_b, st_hi_a, st_hi_b,
        st_push, st_drain
    } state_t;

    state_t      state;
    logic [4:0]  tile;
    logic [1:0]  credits;
    logic [7:0]  tile_id;
    logic [7:0]  data_lo;
    logic [7:0]  data_hi;
    logic [7:0]  bg_y;
    logic [4:0]  map_col;
    logic [12:0] map_addr;
    logic [12:0] tile_base;
    logic [12:0] data_addr;

    //////////////////////////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////////////////////////

    assign bg_y     = line + cfg.scy;
    assign map_col  = cfg.scx[7:3] + tile;  // Wraps at 32 tiles
    assign map_addr = (cfg.lcdc.f.map_sel ? 13'h1C00 : 13'h1800) + {3'b000, bg_y[7:3], map_col};

    // Signed ids are based at 1000
    assign tile_base = cfg.lcdc.f.data_sel ? {1'b0, tile_id, 4'h0}
                                           : 13'h1000 + {tile_id[7], tile_id, 4'h0};
    assign data_addr = tile_base + {9'd0, bg_y[2:0], 1'b0};

    always_comb
    begin
        case (state)
            st_map_a: fetch_addr = map_addr;
            st_hi_a:  fetch_addr = data_addr | 13'h0001;
            default:  fetch_addr = data_addr;
        endcase
    end

    always_comb
    begin
        case (state)
            st_idle:
                if (line_start)
                    mode = ppu_pkg::oam;  // h count 0 of a visible line
                else if (cfg.lcdc.f.enable && in_vblank)
                    mode = ppu_pkg::vblank;
                else
                    mode = ppu_pkg::hblank;
            st_oam:  mode = ppu_pkg::oam;
            default: mode = ppu_pkg::xfer;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Line FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst || !cfg.lcdc.f.enable)
            state <= st_idle;
        else if (line_start)
            state <= st_oam;
        else
        begin
            case (state)
                st_oam:
                    if (h_count == 9'(oam_cycles - 1))
                        state <= st_map_a;
                st_map_a: state <= st_map_b;
                st_map_b: state <= st_lo_a;
                st_lo_a:  state <= st_lo_b;
                st_lo_b:  state <= st_hi_a;
                st_hi_a:  state <= st_hi_b;
                st_hi_b:  state <= st_push;
                st_push:  // Stalls here with no credit
                    if (credits != 2'd0)
                        state <= (tile == 5'(ppu_pkg::tiles_per_line - 1)) ? st_drain : st_map_a;
                st_drain:
                    if (line_done)
                        state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            st_map_b: tile_id <= fetch_data;
            st_lo_b:  data_lo <= fetch_data;
            st_hi_b:  data_hi <= fetch_data;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || line_start)
            tile <= 5'd0;
        else if (push)
            tile <= tile + 5'd1;
    end

    // One credit per free tile slot in the shifter
    always_ff @(posedge clk)
    begin
        if (rst || line_start)
            credits <= 2'd2;
        else if (push && !credit_return)
            credits <= credits - 2'd1;
        else if (credit_return && !push)
            credits <= credits + 2'd1;
    end

    assign push      = (state == st_push) && (credits != 2'd0);
    assign tile_bits = {data_hi, data_lo};

endmodule

`default_nettype wire

//--- logic/ppu_pixel_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_pixel_shifter (
    input  wire        clk,
    input  wire        rst,
    input  wire        bg_en,
    input  wire [7:0]  bgp,
    input  wire        push,
    input  wire [15:0] tile_bits,
    output logic [1:0] pixel,
    output logic       pixel_valid,
    output logic       credit_return,
    output logic       line_done
);

    logic [15:0] tile_buf [2];  // Ping-pong pair
    logic [1:0]  full;
    logic        wr_sel;
    logic        rd_sel;
    logic [2:0]  bit_idx;       // Pixel within the current tile
    logic [7:0]  pix_count;
    logic [15:0] cur;
    logic [1:0]  color;

    assign cur         = tile_buf[rd_sel];
    assign pixel_valid = full[rd_sel];

    // Leftmost pixel is bit 7, high bit from the second byte
    assign color = bg_en ? {cur[{1'b1, ~bit_idx}], cur[{1'b0, ~bit_idx}]} : 2'b00;
    assign pixel = bgp[{color, 1'b0} +: 2];

    assign credit_return = pixel_valid && (bit_idx == 3'd7);
    assign line_done     = pixel_valid && (pix_count == 8'(ppu_pkg::pixels_per_line - 1));

    always_ff @(posedge clk)
    begin
        if (push)
            tile_buf[wr_sel] <= tile_bits;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full      <= 2'b00;
            wr_sel    <= 1'b0;
            rd_sel    <= 1'b0;
            bit_idx   <= 3'd0;
            pix_count <= 8'd0;
        end
        else
        begin
            if (push)
            begin
                full[wr_sel] <= 1'b1;
                wr_sel       <= !wr_sel;
            end
            if (pixel_valid)
            begin
                bit_idx   <= bit_idx + 3'd1;
                pix_count <= line_done ? 8'd0 : pix_count + 8'd1;
                if (credit_return)  // Tile drained, hand the slot back
                begin
                    full[rd_sel] <= 1'b0;
                    rd_sel       <= !rd_sel;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////////////////////////

    localparam int h_total         = 456;  // Clocks per line
    localparam int v_total         = 154;  // Lines per frame
    localparam int v_blank_lines   = 10;   // Lines 0 to 9 are vblank
    localparam int h_sync_start    = 76;
    localparam int sync_len        = 4;
    localparam int v_sync_start    = 6;
    localparam int oam_cycles      = 80;   // Idle mode 2 at line start
    localparam int pixels_per_line = 160;
    localparam int tiles_per_line  = 20;

    //////////////////////////////////////////////////////////////////////
    // CPU bus map
    //////////////////////////////////////////////////////////////////////

    localparam logic [15:0] addr_lcdc = 16'hFF40;
    localparam logic [15:0] addr_stat = 16'hFF41;
    localparam logic [15:0] addr_scy  = 16'hFF42;
    localparam logic [15:0] addr_scx  = 16'hFF43;
    localparam logic [15:0] addr_ly   = 16'hFF44;  // Read-only
    localparam logic [15:0] addr_bgp  = 16'hFF47;
    localparam logic [15:0] vram_base = 16'h8000;
    localparam logic [15:0] vram_last = 16'h9FFF;

    // Same encoding as STAT bits 1:0
    typedef enum logic [1:0] {
        hblank = 2'd0,
        vblank = 2'd1,
        oam    = 2'd2,
        xfer   = 2'd3
    } ppu_mode_t;

    // LCDC flags, bit 7 first
    typedef struct packed {
        logic enable;
        logic win_map;
        logic win_en;
        logic data_sel;   // 1 = unsigned tiles at 0000
        logic map_sel;    // 1 = map at 1C00
        logic obj_size;
        logic obj_en;
        logic bg_en;
    } lcdc_flags_t;

    // Bus side sees the byte, render side the flags
    typedef union packed {
        logic [7:0]  raw;
        lcdc_flags_t f;
    } lcdc_u;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } cpu_req_t;

    typedef struct packed {
        logic [12:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        re;
    } vram_cpu_t;

    typedef struct packed {
        lcdc_u      lcdc;
        logic [7:0] scx;
        logic [7:0] scy;
    } bg_cfg_t;

endpackage

`default_nettype wire

//--- logic/ppu_timing.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_timing #(
    parameter int h_total       = 456,
    parameter int v_total       = 154,
    parameter int v_blank_lines = 10,
    parameter int h_sync_start  = 76,
    parameter int sync_len      = 4,
    parameter int v_sync_start  = 6
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        enable,
    output logic       hs,
    output logic       vs,
    output logic       line_start,
    output logic       in_vblank,
    output logic [8:0] h_count,
    output logic [7:0] line
);

    logic [7:0] v_count;

    // Both counters sit at 0 while the LCD is off
    always_ff @(posedge clk)
    begin
        if (rst || !enable)
        begin
            h_count <= 9'd0;
            v_count <= 8'd0;
        end
        else if (h_count == 9'(h_total - 1))
        begin
            h_count <= 9'd0;
            if (v_count == 8'(v_total - 1))
                v_count <= 8'd0;
            else
                v_count <= v_count + 8'd1;
        end
        else
        begin
            h_count <= h_count + 9'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sync and line flags
    //////////////////////////////////////////////////////////////////////

    assign hs = (h_count >= 9'(h_sync_start)) && (h_count < 9'(h_sync_start + sync_len));
    assign vs = (v_count >= 8'(v_sync_start)) && (v_count < 8'(v_sync_start + sync_len));

    assign in_vblank  = v_count < 8'(v_blank_lines);
    assign line_start = !in_vblank && (h_count == 9'd0);  // First clock of a visible line

    // Visible lines count from 0, blank lines follow them at 144 to 153
    always_comb
    begin
        if (!enable)
            line = 8'd0;
        else if (in_vblank)
            line = v_count + 8'(v_total - v_blank_lines);
        else
            line = v_count - 8'(v_blank_lines);
    end

endmodule

`default_nettype wire

//--- logic/ppu_top.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire ppu_pkg::cpu_req_t req,
    output logic [7:0]             d_rd,
    output logic                   rd_valid,
    output logic [1:0]             pixel,
    output logic                   pixel_valid,
    output logic                   hs,
    output logic                   vs
);

    wire ppu_pkg::ppu_mode_t mode;
    wire ppu_pkg::vram_cpu_t vram_cpu;
    wire ppu_pkg::bg_cfg_t   cfg;
    wire [7:0]               vram_rdata;
    wire [7:0]               bgp;
    wire [7:0]               line;
    wire [8:0]               h_count;
    wire                     line_start;
    wire                     in_vblank;
    wire [12:0]              fetch_addr;
    wire [7:0]               fetch_data;
    wire                     push;
    wire [15:0]              tile_bits;
    wire                     credit_return;
    wire                     line_done;

    ppu_bus_regs i_ppu_bus_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .mode       (mode),
        .line       (line),
        .vram_cpu   (vram_cpu),
        .vram_rdata (vram_rdata),
        .cfg        (cfg),
        .bgp        (bgp),
        .d_rd       (d_rd),
        .rd_valid   (rd_valid)
    );

    ppu_timing #(
        .h_total       (ppu_pkg::h_total),
        .v_total       (ppu_pkg::v_total),
        .v_blank_lines (ppu_pkg::v_blank_lines),
        .h_sync_start  (ppu_pkg::h_sync_start),
        .sync_len      (ppu_pkg::sync_len),
        .v_sync_start  (ppu_pkg::v_sync_start)
    ) i_ppu_timing (
        .clk        (clk),
        .rst        (rst),
        .enable     (cfg.lcdc.f.enable),
        .hs         (hs),
        .vs         (vs),
        .line_start (line_start),
        .in_vblank  (in_vblank),
        .h_count    (h_count),
        .line       (line)
    );

    ppu_vram i_ppu_vram (
        .clk        (clk),
        .mode       (mode),
        .cpu        (vram_cpu),
        .cpu_rdata  (vram_rdata),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    ppu_fetcher #(
        .oam_cycles (ppu_pkg::oam_cycles)
    ) i_ppu_fetcher (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .line_start    (line_start),
        .in_vblank     (in_vblank),
        .h_count       (h_count),
        .line          (line),
        .mode          (mode),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .push          (push),
        .tile_bits     (tile_bits),
        .credit_return (credit_return),
        .line_done     (line_done)
    );

    ppu_pixel_shifter i_ppu_pixel_shifter (
        .clk           (clk),
        .rst           (rst),
        .bg_en         (cfg.lcdc.f.bg_en),
        .bgp           (bgp),
        .push          (push),
        .tile_bits     (tile_bits),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid),
        .credit_return (credit_return),
        .line_done     (line_done)
    );

endmodule

`default_nettype wire

//--- logic/ppu_vram.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_vram (
    input  wire                     clk,
    input  wire ppu_pkg::ppu_mode_t mode,
    input  wire ppu_pkg::vram_cpu_t cpu,
    output logic [7:0]              cpu_rdata,
    input  wire [12:0]              fetch_addr,
    output logic [7:0]              fetch_data
);

    logic [7:0]  mem [8192];
    logic [7:0]  rdata;
    logic [12:0] addr;
    logic        fetch_owns;
    logic        cpu_blocked;  // Last CPU read hit pixel transfer

    // Single port, the fetcher owns it through mode 3
    assign fetch_owns = (mode == ppu_pkg::xfer);
    assign addr       = fetch_owns ? fetch_addr : cpu.addr;

    always_ff @(posedge clk)
    begin
        if (cpu.we && !fetch_owns)
            mem[addr] <= cpu.wdata;
        rdata <= mem[addr];
    end

    always_ff @(posedge clk)
    begin
        if (cpu.re)
            cpu_blocked <= fetch_owns;
    end

    assign cpu_rdata  = cpu_blocked ? 8'hFF : rdata;
    assign fetch_data = rdata;

endmodule

`default_nettype wire

//--- tb.f
logic/ppu_pkg.sv
logic/ppu_bus_regs.sv
logic/ppu_timing.sv
logic/ppu_vram.sv
logic/ppu_fetcher.sv
logic/ppu_pixel_shifter.sv
logic/ppu_top.sv
verification/ppu_chk.sv
verification/ppu_tb.sv

//--- verification/ppu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_chk (
    input wire                     clk,
    input wire                     rst,
    input wire ppu_pkg::cpu_req_t  req,
    input wire                     rd_valid,
    input wire                     pixel_valid,
    input wire ppu_pkg::ppu_mode_t mode,
    input wire [1:0]               credits
);

    int fail_count = 0;  // Read by the testbench

    credits_bounded: assert property (@(posedge clk) disable iff (rst) credits <= 2'd2)
    else
    begin
        fail_count++;
        $error("Fetcher credit count went above two");
    end

    pixels_in_xfer: assert property (@(posedge clk) disable iff (rst)
        pixel_valid |-> mode == ppu_pkg::xfer)
    else
    begin
        fail_count++;
        $error("pixel_valid high outside pixel transfer");
    end

    // Fixed read latency, both directions
    rd_to_valid: assert property (@(posedge clk) disable iff (rst) req.rd |-> ##2 rd_valid)
    else
    begin
        fail_count++;
        $error("rd_valid missing two cycles after rd");
    end

    valid_from_rd: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(req.rd, 2))
    else
    begin
        fail_count++;
        $error("rd_valid without rd two cycles earlier");
    end

endmodule

bind ppu_top ppu_chk i_ppu_chk (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .rd_valid    (rd_valid),
    .pixel_valid (pixel_valid),
    .mode        (mode),
    .credits     (i_ppu_fetcher.credits)
);

`default_nettype wire

//--- verification/ppu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_tb;

    localparam int sig_hs  = 0;
    localparam int sig_vs  = 1;
    localparam int sig_pix = 2;
    localparam int sig_rdv = 3;

    localparam int line_limit     = ppu_pkg::h_total + 8;
    localparam int frame_limit    = ppu_pkg::h_total * ppu_pkg::v_total + 8;
    localparam int lines_captured = 4;

    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp;
    } bus_row_t;

    typedef struct packed {
        logic       map_sel;
        logic       data_sel;
        logic [7:0] scx;
        logic [7:0] scy;
        logic [7:0] bgp;
        logic       bg_en;
    } scene_t;

    logic              clk;
    logic              rst;
    ppu_pkg::cpu_req_t req;
    logic [7:0]        d_rd;
    logic              rd_valid;
    logic [1:0]        pixel;
    logic              pixel_valid;
    logic              hs;
    logic              vs;

    logic [7:0] vram_model [8192];
    integer     seed;
    scene_t     cur;

    //////////////////////////////////////////////////////////////////////
    // Stimulus tables
    //////////////////////////////////////////////////////////////////////

    bus_row_t bus_rows [24] = '{
        '{1'b0, 16'hFF47, 8'h00, 8'hFC},  // BGP reset value
        '{1'b1, 16'hFF40, 8'h5A, 8'h00},
        '{1'b0, 16'hFF40, 8'h00, 8'h5A},
        '{1'b1, 16'hFF40, 8'h00, 8'h00},
        '{1'b0, 16'hFF40, 8'h00, 8'h00},
        '{1'b1, 16'hFF42, 8'h3C, 8'h00},
        '{1'b0, 16'hFF42, 8'h00, 8'h3C},
        '{1'b1, 16'hFF43, 8'hA7, 8'h00},
        '{1'b0, 16'hFF43, 8'h00, 8'hA7},
        '{1'b1, 16'hFF47, 8'h1B, 8'h00},
        '{1'b0, 16'hFF47, 8'h00, 8'h1B},
        '{1'b1, 16'hFF41, 8'h7B, 8'h00},
        '{1'b0, 16'hFF41, 8'h00, 8'hF8},  // Mode bits stay hblank
        '{1'b1, 16'hFF41, 8'h03, 8'h00},
        '{1'b0, 16'hFF41, 8'h00, 8'h80},
        '{1'b1, 16'hFF44, 8'h55, 8'h00},  // LY is read-only
        '{1'b0, 16'hFF44, 8'h00, 8'h00},
        '{1'b0, 16'hFF45, 8'h00, 8'hFF},
        '{1'b0, 16'hFF46, 8'h00, 8'hFF},
        '{1'b0, 16'hFE00, 8'h00, 8'hFF},  // OAM
        '{1'b1, 16'hFE10, 8'h12, 8'h00},
        '{1'b0, 16'hFE10, 8'h00, 8'hFF},
        '{1'b0, 16'hFF4B, 8'h00, 8'hFF},
        '{1'b0, 16'hFF40, 8'h00, 8'h00}
    };

    // map_sel, data_sel, scx, scy, bgp, bg_en
    scene_t scenes [4] = '{
        '{1'b0, 1'b1, 8'h00, 8'h00, 8'hE4, 1'b1},
        '{1'b1, 1'b0, 8'h2B, 8'h05, 8'h1B, 1'b1},
        '{1'b1, 1'b1, 8'hF8, 8'hFE, 8'h6C, 1'b1},  // Wraps in x and y
        '{1'b0, 1'b0, 8'h10, 8'h7E, 8'h93, 1'b0}
    };

    ppu_top i_ppu_top (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .d_rd        (d_rd),
        .rd_valid    (rd_valid),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .hs          (hs),
        .vs          (vs)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers that run from a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            fail_stop($sformatf("FAILED %s expected %0h actual %0h", name, expected, actual));
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            sig_hs:  return hs;
            sig_vs:  return vs;
            sig_pix: return pixel_valid;
            default: return rd_valid;
        endcase
    endfunction

    task automatic wait_until(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (probe(sel) !== level)
        begin
            if (cycles >= limit)
                fail_stop({"Timed out waiting for ", what});
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        req.addr  = addr;
        req.wdata = data;
        req.rd    = 1'b0;
        req.wr    = 1'b1;
        @(negedge clk);
        req.wr = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input logic [7:0] expected);
        int cycles;
        req.addr = addr;
        req.rd   = 1'b1;
        req.wr   = 1'b0;
        @(negedge clk);
        req.rd = 1'b0;
        wait_until(sig_rdv, 1'b1, 4, "read data valid", cycles);
        check(name, expected, d_rd);
    endtask

    // Background pixel from the addressing and palette rules
    function automatic logic [1:0] model_pixel(input int ln, input int x);
        int         bg_y;
        int         col;
        int         map_a;
        int         id;
        int         row_a;
        int         b;
        int         c;
        logic [7:0] lo;
        logic [7:0] hi;
        bg_y  = (ln + cur.scy) % 256;
        col   = ((cur.scx >> 3) + x / 8) % 32;  // Fine scroll bits ignored
        map_a = (cur.map_sel ? 'h1C00 : 'h1800) + (bg_y / 8) * 32 + col;
        id    = vram_model[map_a];
        if (!cur.data_sel)
            id = 'h100 + (id >= 128 ? id - 256 : id);  // Signed ids around 1000
        row_a = id * 16 + (bg_y % 8) * 2;
        lo    = vram_model[row_a];
        hi    = vram_model[row_a + 1];
        b     = 7 - x % 8;
        c     = cur.bg_en ? {hi[b], lo[b]} : 0;
        return cur.bgp[2 * c +: 2];
    endfunction

    // Runs from one hs rise to the next, checking pixels and hs shape
    task automatic capture_line(input int scn, input int ln);
        int   n;
        int   cycles;
        int   width;
        logic seen_low;
        n        = 0;
        cycles   = 0;
        width    = 0;
        seen_low = 1'b0;
        while (!(seen_low && hs))
        begin
            @(negedge clk);
            cycles++;
            if (cycles > line_limit)
                fail_stop("Timed out waiting for the next hs rising edge");
            if (pixel_valid)
            begin
                if (n < ppu_pkg::pixels_per_line)
                    check($sformatf("scene %0d line %0d pixel %0d", scn, ln, n),
                          model_pixel(ln, n), pixel);
                n++;
            end
            if (!hs && !seen_low)
            begin
                seen_low = 1'b1;
                width    = cycles;
            end
        end
        check("hs width", ppu_pkg::sync_len, width);
        check("hs period", ppu_pkg::h_total, cycles);
        check($sformatf("pixel count line %0d", ln), ppu_pkg::pixels_per_line, n);
    endtask

    task automatic run_scene(input int scn);
        int          cycles;
        logic [12:0] a;
        cur = scenes[scn];
        bus_write(ppu_pkg::addr_scx, cur.scx);
        bus_write(ppu_pkg::addr_scy, cur.scy);
        bus_write(ppu_pkg::addr_bgp, cur.bgp);
        bus_write(ppu_pkg::addr_lcdc, {1'b1, 2'b00, cur.data_sel, cur.map_sel, 2'b00, cur.bg_en});
        wait_until(sig_vs, 1'b1, frame_limit, "vs to rise", cycles);
        wait_until(sig_vs, 1'b0, frame_limit, "vs to fall", cycles);
        check("vs width", ppu_pkg::sync_len * ppu_pkg::h_total, cycles);
        wait_until(sig_hs, 1'b1, line_limit, "hs of line 0", cycles);
        for (int ln = 0; ln < lines_captured; ln++)
            capture_line(scn, ln);
        read_check("LY", ppu_pkg::addr_ly, 8'(lines_captured));
        wait_until(sig_hs, 1'b0, line_limit, "hs to fall", cycles);
        wait_until(sig_hs, 1'b1, line_limit, "hs to rise", cycles);
        read_check("LY", ppu_pkg::addr_ly, 8'(lines_captured + 1));

        // CPU locked out of VRAM during pixel transfer
        a = 13'h0123 + 13'(scn);
        wait_until(sig_pix, 1'b1, line_limit, "pixel_valid", cycles);
        read_check("VRAM read in xfer", ppu_pkg::vram_base + a, 8'hFF);
        wait_until(sig_pix, 1'b1, line_limit, "pixel_valid", cycles);
        bus_write(ppu_pkg::vram_base + a, ~vram_model[a]);
        wait_until(sig_vs, 1'b1, frame_limit, "vs in next frame", cycles);
        read_check("VRAM after blocked write", ppu_pkg::vram_base + a, vram_model[a]);
        read_check("LY in vblank", ppu_pkg::addr_ly,
                   8'((ppu_pkg::v_total - ppu_pkg::v_blank_lines) + ppu_pkg::v_sync_start));
        bus_write(ppu_pkg::addr_lcdc, 8'h00);  // Off during vblank
    endtask

    always @(negedge clk)
    begin
        if (!rst && i_ppu_top.i_ppu_chk.fail_count != 0)
            fail_stop("A concurrent assertion in ppu_chk failed");
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed = 32'hf0c7fe48;
        rst  = 1'b1;
        req  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (bus_rows[i])
        begin
            if (bus_rows[i].wr)
                bus_write(bus_rows[i].addr, bus_rows[i].data);
            else
                read_check($sformatf("register row %0d", i), bus_rows[i].addr, bus_rows[i].exp);
        end

        // Whole VRAM with the LCD off
        for (int a = 0; a < 8192; a++)
        begin
            vram_model[a] = 8'($random(seed));
            bus_write(ppu_pkg::vram_base + 16'(a), vram_model[a]);
        end
        for (int a = 0; a < 8192; a++)
            read_check($sformatf("VRAM %04h", a), ppu_pkg::vram_base + 16'(a), vram_model[a]);

        foreach (scenes[s])
            run_scene(s);

        if (i_ppu_top.i_ppu_chk.fail_count == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
            fail_stop("Concurrent assertion failures were counted");
    end

endmodule

`default_nettype wire
